/* source/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath widths
`define XLEN           32
`define INST_LEN       32
`define REG_ADDRWIDTH  5
`define CSR_ADDRWIDTH  12

// data memory geometry
`define DMEM_DEPTH     256
`define DMEM_LATENCY   2    // request accepted to response valid

// addi x0, x0, 0
`define INST_NOP       32'h0000_0013

// machine-mode trap CSRs
`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343

// mstatus bit positions
`define MSTATUS_MIE    3
`define MSTATUS_MPIE   7

`endif

/* source/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  typedef enum logic {
    MS_IDLE = 1'b0,
    MS_WAIT = 1'b1
  } ms_state_e;

  // execute stage output, one instruction
  typedef struct packed {
    logic [`XLEN-1:0]          pc;
    logic [`INST_LEN-1:0]      inst;
    mem_op_e                   mem_op;
    logic [`XLEN-1:0]          addr;        // alu result, byte address for loads/stores
    logic [`XLEN-1:0]          store_data;
    logic [`REG_ADDRWIDTH-1:0] rd;
    logic                      rd_we;
    logic                      csr_we;
    logic [`CSR_ADDRWIDTH-1:0] csr_addr;
    logic [`XLEN-1:0]          csr_wdata;
    logic                      trap;
    logic [`XLEN-1:0]          cause;
    logic [`XLEN-1:0]          tval;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]          pc;
    logic [`INST_LEN-1:0]      inst;
    logic [`REG_ADDRWIDTH-1:0] rd;
    logic                      rd_we;
    logic [`XLEN-1:0]          result;      // load data or alu result
    logic                      csr_we;
    logic [`CSR_ADDRWIDTH-1:0] csr_addr;
    logic [`XLEN-1:0]          csr_wdata;
    logic                      trap;
    logic [`XLEN-1:0]          cause;
    logic [`XLEN-1:0]          tval;
  } mem_wb_t;

  typedef struct packed {
    logic [`XLEN-1:0]          pc;
    logic [`INST_LEN-1:0]      inst;
    logic [`REG_ADDRWIDTH-1:0] rd;
    logic                      rd_we;
    logic [`XLEN-1:0]          rd_data;
    logic                      trap;
    logic [`XLEN-1:0]          redirect_pc;
  } commit_t;

endpackage

/* source/data_mem.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module data_mem (
  input  logic             clk,
  input  logic             rst,
  input  logic             req_valid_i,
  input  logic             req_we_i,
  input  logic [`XLEN-1:0] req_addr_i,
  input  logic [`XLEN-1:0] req_wdata_i,
  output logic             rsp_valid_o,
  output logic [`XLEN-1:0] rsp_rdata_o
);

  localparam int AW = $clog2(`DMEM_DEPTH);

  logic [`XLEN-1:0]         mem [`DMEM_DEPTH];
  logic [`DMEM_DEPTH-1:0]   written;          // per-word, unwritten words read as zero
  logic [AW-1:0]            word_idx;
  logic [`XLEN-1:0]         rd_word;
  logic [`DMEM_LATENCY-1:0] dl_valid;
  logic [`XLEN-1:0]         dl_data [`DMEM_LATENCY];

  assign word_idx = req_addr_i[AW+1:2];  // word addressed, low bits dropped
  assign rd_word  = written[word_idx] ? mem[word_idx] : '0;

  always_ff @(posedge clk) begin
    if (req_valid_i && req_we_i) begin
      mem[word_idx] <= req_wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;
    end else if (req_valid_i && req_we_i) begin
      written[word_idx] <= 1'b1;
    end
  end

  // response delay line
  always_ff @(posedge clk) begin
    if (rst) begin
      dl_valid <= '0;
    end else begin
      dl_valid[0] <= req_valid_i;
      for (int i = 1; i < `DMEM_LATENCY; i++) begin
        dl_valid[i] <= dl_valid[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    dl_data[0] <= rd_word;  // old word, also for stores
    for (int i = 1; i < `DMEM_LATENCY; i++) begin
      dl_data[i] <= dl_data[i-1];
    end
  end

  assign rsp_valid_o = dl_valid[`DMEM_LATENCY-1];
  assign rsp_rdata_o = dl_data[`DMEM_LATENCY-1];

endmodule

/* source/mem_stage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module mem_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  core_pkg::ex_mem_t   in_data_i,
  output logic                req_valid_o,
  output logic                req_we_o,
  output logic [`XLEN-1:0]    req_addr_o,
  output logic [`XLEN-1:0]    req_wdata_o,
  input  logic                rsp_valid_i,
  input  logic [`XLEN-1:0]    rsp_rdata_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output core_pkg::mem_wb_t   out_data_o
);

  core_pkg::ms_state_e state_q;
  core_pkg::ex_mem_t   pay_q;
  logic                out_valid_q;  // non-memory result waiting downstream
  logic                issued_q;     // request for pay_q sent
  logic                in_fire;
  logic                is_mem;
  logic                rsp_hit;
  logic [`XLEN-1:0]    result;

  assign in_ready_o = !rst && (state_q == core_pkg::MS_IDLE) && out_ready_i && !flush_i;
  assign in_fire    = in_valid_i && in_ready_o;
  // trapping ops never touch memory
  assign is_mem     = (in_data_i.mem_op != core_pkg::MEM_NONE) && !in_data_i.trap;

  // issue only once downstream can take the response
  assign req_valid_o = (state_q == core_pkg::MS_WAIT) && !issued_q && out_ready_i && !flush_i;
  assign req_we_o    = (pay_q.mem_op == core_pkg::MEM_STORE);
  assign req_addr_o  = pay_q.addr;
  assign req_wdata_o = pay_q.store_data;

  assign rsp_hit     = (state_q == core_pkg::MS_WAIT) && issued_q && rsp_valid_i;
  assign out_valid_o = out_valid_q || rsp_hit;
  assign result      = (rsp_hit && pay_q.mem_op == core_pkg::MEM_LOAD) ? rsp_rdata_i : pay_q.addr;

  always_comb begin
    out_data_o.pc        = pay_q.pc;
    out_data_o.inst      = pay_q.inst;
    out_data_o.rd        = pay_q.rd;
    out_data_o.rd_we     = pay_q.rd_we;
    out_data_o.result    = result;
    out_data_o.csr_we    = pay_q.csr_we;
    out_data_o.csr_addr  = pay_q.csr_addr;
    out_data_o.csr_wdata = pay_q.csr_wdata;
    out_data_o.trap      = pay_q.trap;
    out_data_o.cause     = pay_q.cause;
    out_data_o.tval      = pay_q.tval;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= core_pkg::MS_IDLE;
      out_valid_q <= 1'b0;
      issued_q    <= 1'b0;
    end else if (flush_i) begin
      // drop whatever is held; a late response is ignored in idle
      state_q     <= core_pkg::MS_IDLE;
      out_valid_q <= 1'b0;
      issued_q    <= 1'b0;
    end else begin
      case (state_q)
        core_pkg::MS_IDLE: begin
          if (out_valid_q && out_ready_i) begin
            out_valid_q <= 1'b0;
          end
          if (in_fire) begin
            if (is_mem) begin
              state_q  <= core_pkg::MS_WAIT;
              issued_q <= 1'b0;
            end else begin
              out_valid_q <= 1'b1;
            end
          end
        end
        core_pkg::MS_WAIT: begin
          if (req_valid_o) begin
            issued_q <= 1'b1;
          end
          if (rsp_hit) begin
            state_q <= core_pkg::MS_IDLE;  // result taken this cycle
          end
        end
        default: state_q <= core_pkg::MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      pay_q <= in_data_i;
    end
  end

endmodule

/* source/mem_wb_reg.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module mem_wb_reg (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  core_pkg::mem_wb_t in_data_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output core_pkg::mem_wb_t out_data_o
);

  core_pkg::mem_wb_t main_q;
  core_pkg::mem_wb_t buf_q;     // capture buffer for data that cannot wait
  logic              main_valid;
  logic              buf_valid;
  logic              main_free;
  logic              in_fire;

  // flushed entry turns into a harmless nop
  function automatic core_pkg::mem_wb_t kill_entry(core_pkg::mem_wb_t e);
    core_pkg::mem_wb_t k;
    k        = e;
    k.rd_we  = 1'b0;
    k.csr_we = 1'b0;
    k.trap   = 1'b0;
    k.inst   = `INST_NOP;
    return k;
  endfunction

  assign in_ready_o  = !buf_valid;  // room while the buffer is empty
  assign in_fire     = in_valid_i && in_ready_o;
  assign main_free   = !main_valid || out_ready_i;
  assign out_valid_o = main_valid;
  assign out_data_o  = main_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      buf_valid  <= 1'b0;
    end else if (flush_i) begin
      main_valid <= 1'b0;
      buf_valid  <= 1'b0;
    end else if (main_free) begin
      // older buffered item goes first, input is blocked meanwhile
      main_valid <= buf_valid || in_fire;
      buf_valid  <= 1'b0;
    end else if (in_fire) begin
      buf_valid <= 1'b1;  // main stalled, park the arrival
    end
  end

  always_ff @(posedge clk) begin
    if (flush_i) begin
      main_q <= kill_entry(main_q);
      buf_q  <= kill_entry(buf_q);
    end else if (main_free) begin
      main_q <= buf_valid ? buf_q : in_data_i;
    end else if (in_fire) begin
      buf_q <= in_data_i;
    end
  end

endmodule

/* source/wb_stage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module wb_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  core_pkg::mem_wb_t in_data_i,
  output logic              commit_valid_o,
  input  logic              commit_ready_i,
  output core_pkg::commit_t commit_o,
  output logic              flush_o,
  output logic [`XLEN-1:0]  redirect_pc_o
);

  core_pkg::mem_wb_t wb_q;
  logic              cv_q;
  logic              flush_q;
  logic [`XLEN-1:0]  redirect_q;
  logic              in_fire;
  logic              commit_fire;
  logic [`XLEN-1:0]  csr_rdata;

  logic [`XLEN-1:0]  rf [32];
  logic [`XLEN-1:0]  csr_mstatus;
  logic [`XLEN-1:0]  csr_mepc;
  logic [`XLEN-1:0]  csr_mcause;
  logic [`XLEN-1:0]  csr_mtval;
  logic [`XLEN-1:0]  csr_mtvec;

  assign commit_fire = cv_q && commit_ready_i;
  // nothing younger than a trap gets in, nor anything during the flush
  assign in_ready_o  = !flush_q && (!cv_q || (commit_ready_i && !wb_q.trap));
  assign in_fire     = in_valid_i && in_ready_o;

  assign commit_valid_o = cv_q;
  assign flush_o        = flush_q;
  assign redirect_pc_o  = redirect_q;

  // old value of the addressed csr
  always_comb begin
    case (wb_q.csr_addr)
      `CSR_MSTATUS: csr_rdata = csr_mstatus;
      `CSR_MEPC:    csr_rdata = csr_mepc;
      `CSR_MCAUSE:  csr_rdata = csr_mcause;
      `CSR_MTVAL:   csr_rdata = csr_mtval;
      `CSR_MTVEC:   csr_rdata = csr_mtvec;
      default:      csr_rdata = '0;
    endcase
  end

  always_comb begin
    commit_o.pc          = wb_q.pc;
    commit_o.inst        = wb_q.inst;
    commit_o.rd          = wb_q.rd;
    commit_o.rd_we       = wb_q.rd_we && !wb_q.trap;
    commit_o.rd_data     = wb_q.csr_we ? csr_rdata : wb_q.result;
    commit_o.trap        = wb_q.trap;
    commit_o.redirect_pc = wb_q.trap ? csr_mtvec : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cv_q        <= 1'b0;
      flush_q     <= 1'b0;
      csr_mstatus <= '0;
      csr_mepc    <= '0;
      csr_mcause  <= '0;
      csr_mtval   <= '0;
      csr_mtvec   <= '0;
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else begin
      flush_q <= commit_fire && wb_q.trap;  // one cycle after the trap commits
      if (in_fire) begin
        cv_q <= 1'b1;
      end else if (commit_fire) begin
        cv_q <= 1'b0;
      end

      if (commit_fire && wb_q.trap) begin
        csr_mepc                   <= wb_q.pc;
        csr_mcause                 <= wb_q.cause;
        csr_mtval                  <= wb_q.tval;
        csr_mstatus[`MSTATUS_MPIE] <= csr_mstatus[`MSTATUS_MIE];
        csr_mstatus[`MSTATUS_MIE]  <= 1'b0;
      end else if (commit_fire) begin
        if (wb_q.csr_we) begin
          case (wb_q.csr_addr)
            `CSR_MSTATUS: csr_mstatus <= wb_q.csr_wdata;
            `CSR_MEPC:    csr_mepc    <= wb_q.csr_wdata;
            `CSR_MCAUSE:  csr_mcause  <= wb_q.csr_wdata;
            `CSR_MTVAL:   csr_mtval   <= wb_q.csr_wdata;
            `CSR_MTVEC:   csr_mtvec   <= wb_q.csr_wdata;
            default:      ;  // unknown csr, write dropped
          endcase
        end
        if (wb_q.rd_we && wb_q.rd != '0) begin
          rf[wb_q.rd] <= commit_o.rd_data;  // x0 stays zero
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      wb_q <= in_data_i;
    end
    if (commit_fire && wb_q.trap) begin
      redirect_q <= csr_mtvec;
    end
  end

endmodule

/* source/mem_wb_top.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module mem_wb_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  core_pkg::ex_mem_t in_data_i,
  output logic              commit_valid_o,
  input  logic              commit_ready_i,
  output core_pkg::commit_t commit_o,
  output logic              flush_o,
  output logic [`XLEN-1:0]  redirect_pc_o
);

  // memory port
  logic             req_valid;
  logic             req_we;
  logic [`XLEN-1:0] req_addr;
  logic [`XLEN-1:0] req_wdata;
  logic             rsp_valid;
  logic [`XLEN-1:0] rsp_rdata;

  // stage streams
  logic              ms_valid;
  logic              ms_ready;
  core_pkg::mem_wb_t ms_data;
  logic              wb_valid;
  logic              wb_ready;
  core_pkg::mem_wb_t wb_data;

  data_mem u_dmem (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata)
  );

  mem_stage u_mem_stage (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_o),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .req_valid_o (req_valid),
    .req_we_o    (req_we),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .rsp_valid_i (rsp_valid),
    .rsp_rdata_i (rsp_rdata),
    .out_valid_o (ms_valid),
    .out_ready_i (ms_ready),
    .out_data_o  (ms_data)
  );

  mem_wb_reg u_mem_wb_reg (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_o),
    .in_valid_i  (ms_valid),
    .in_ready_o  (ms_ready),
    .in_data_i   (ms_data),
    .out_valid_o (wb_valid),
    .out_ready_i (wb_ready),
    .out_data_o  (wb_data)
  );

  wb_stage u_wb_stage (
    .clk            (clk),
    .rst            (rst),
    .in_valid_i     (wb_valid),
    .in_ready_o     (wb_ready),
    .in_data_i      (wb_data),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_o       (commit_o),
    .flush_o        (flush_o),
    .redirect_pc_o  (redirect_pc_o)
  );

endmodule

/* sim/tb_mem_wb.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module tb_mem_wb;

  localparam int K_ALU   = 0;
  localparam int K_LOAD  = 1;
  localparam int K_STORE = 2;
  localparam int K_CSR   = 3;
  localparam int K_TRAP  = 4;
  localparam logic [11:0] CSR_LIST [5] = '{`CSR_MSTATUS, `CSR_MEPC, `CSR_MCAUSE,
                                           `CSR_MTVAL, `CSR_MTVEC};

  logic              clk;
  logic              rst;
  logic              in_valid_i;
  logic              in_ready_o;
  core_pkg::ex_mem_t in_data_i;
  logic              commit_valid_o;
  logic              commit_ready_i;
  core_pkg::commit_t commit_o;
  logic              flush_o;
  logic [`XLEN-1:0]  redirect_pc_o;

  integer            seed;
  int                errors;
  int                dropped;
  int                ready_mode;   // 0 always ready, 1 coin flip, 2 long stalls
  int                stall_left;
  logic [31:0]       pc_next;
  logic              drop_younger;  // between a trap's acceptance and its flush
  logic              flush_due;
  logic [31:0]       trap_target;
  core_pkg::ex_mem_t pending [$];  // accepted, not yet committed

  // reference state
  logic [31:0] m_mem [`DMEM_DEPTH];
  logic [31:0] m_rf [32];
  logic [31:0] m_csr [logic [11:0]];

  mem_wb_top mem_wb_top_i (.*);

  always #10 clk = ~clk;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "run aborted");
  endtask

  // expected commit for the next instruction in order, advances the model
  function automatic core_pkg::commit_t model_commit(input core_pkg::ex_mem_t op);
    core_pkg::commit_t c;
    logic [31:0]       st;
    int                idx;
    idx       = int'((op.addr >> 2) % `DMEM_DEPTH);
    c         = '0;
    c.pc      = op.pc;
    c.inst    = op.inst;
    c.rd      = op.rd;
    c.trap    = op.trap;
    c.rd_we   = op.rd_we && !op.trap;
    c.rd_data = op.addr;  // alu result unless load or csr
    if (op.trap) begin
      c.redirect_pc        = m_csr[`CSR_MTVEC];
      m_csr[`CSR_MEPC]     = op.pc;
      m_csr[`CSR_MCAUSE]   = op.cause;
      m_csr[`CSR_MTVAL]    = op.tval;
      st                   = m_csr[`CSR_MSTATUS];
      st[`MSTATUS_MPIE]    = st[`MSTATUS_MIE];
      st[`MSTATUS_MIE]     = 1'b0;
      m_csr[`CSR_MSTATUS]  = st;
    end else begin
      if (op.csr_we) begin
        c.rd_data = m_csr.exists(op.csr_addr) ? m_csr[op.csr_addr] : 32'd0;
        if (m_csr.exists(op.csr_addr)) m_csr[op.csr_addr] = op.csr_wdata;
      end else if (op.mem_op == core_pkg::MEM_LOAD) begin
        c.rd_data = m_mem[idx];
      end else if (op.mem_op == core_pkg::MEM_STORE) begin
        m_mem[idx] = op.store_data;
      end
      if (c.rd_we && op.rd != 5'd0) m_rf[op.rd] = c.rd_data;  // x0 never written
    end
    return c;
  endfunction

  function automatic core_pkg::ex_mem_t make_op(input int kind);
    core_pkg::ex_mem_t op;
    logic [31:0]       r;
    op        = '0;
    r         = $random(seed);
    op.pc     = pc_next;
    op.inst   = $random(seed);
    op.rd     = r[4:0];
    op.rd_we  = 1'b1;
    op.addr   = $random(seed);
    op.mem_op = core_pkg::MEM_NONE;
    pc_next   = pc_next + 32'd4;
    case (kind)
      K_LOAD: begin
        op.mem_op = core_pkg::MEM_LOAD;
        op.addr   = ((r >> 8) % `DMEM_DEPTH) << 2;
      end
      K_STORE: begin
        op.mem_op     = core_pkg::MEM_STORE;
        op.addr       = ((r >> 8) % `DMEM_DEPTH) << 2;
        op.store_data = $random(seed);
        op.rd_we      = 1'b0;
      end
      K_CSR: begin
        op.csr_we    = 1'b1;
        op.csr_addr  = CSR_LIST[int'((r >> 16) % 5)];
        op.csr_wdata = $random(seed);
      end
      K_TRAP: begin
        op.trap  = 1'b1;
        op.cause = {29'd0, r[7:5]};
        op.tval  = $random(seed);
      end
      default: ;
    endcase
    return op;
  endfunction

  // one cycle forward, commit_ready_i follows the current mode
  task automatic step_cycle();
    logic [31:0] r;
    @(negedge clk);
    r = $random(seed);
    if (ready_mode == 0) begin
      commit_ready_i = 1'b1;
    end else if (ready_mode == 1) begin
      commit_ready_i = r[0];
    end else if (stall_left > 0) begin
      commit_ready_i = 1'b0;
      stall_left--;
    end else begin
      commit_ready_i = (r[2:0] != 3'd0);
      if (r[2:0] == 3'd0) stall_left = 6 + int'(r[7:4]);
    end
  endtask

  task automatic send_op(input core_pkg::ex_mem_t op);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    in_valid_i = 1'b1;
    in_data_i  = op;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready_o;
      step_cycle();
      waited++;
      if (!taken && waited > 500) report_failure("input never accepted by in_ready_o");
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_mem(input int kind, input int word, input logic [31:0] data);
    core_pkg::ex_mem_t op;
    op            = make_op(kind);
    op.addr       = 32'(word) << 2;
    op.store_data = data;
    send_op(op);
  endtask

  task automatic send_csr(input logic [11:0] addr, input logic [31:0] data);
    core_pkg::ex_mem_t op;
    op           = make_op(K_CSR);
    op.csr_addr  = addr;
    op.csr_wdata = data;
    send_op(op);
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    while (pending.size() != 0 || commit_valid_o || drop_younger) begin
      step_cycle();
      waited++;
      if (waited > 3000) report_failure({"pipeline did not drain after ", what});
    end
  endtask

  // record accepted instructions, skip the ones a trap will flush
  always @(posedge clk) begin
    if (rst) begin
      drop_younger = 1'b0;
    end else begin
      if (flush_o) drop_younger = 1'b0;
      if (in_valid_i && in_ready_o) begin
        if (drop_younger) dropped++;
        else pending.push_back(in_data_i);
        if (in_data_i.trap) drop_younger = 1'b1;
      end
    end
  end

  // compare every commit transfer with the model
  always @(posedge clk) begin
    core_pkg::commit_t exp_c;
    core_pkg::ex_mem_t op;
    if (!rst) begin
      check_value(32'(flush_o), 32'(flush_due), "flush_o");
      if (flush_o) check_value(redirect_pc_o, trap_target, "redirect_pc_o");
      flush_due = 1'b0;
      if (commit_valid_o && commit_ready_i) begin
        if (pending.size() == 0) report_failure("commit without an accepted instruction");
        op    = pending.pop_front();
        exp_c = model_commit(op);
        check_value(commit_o.pc, exp_c.pc, "commit pc");
        check_value(commit_o.inst, exp_c.inst, "commit inst");
        check_value(32'(commit_o.rd), 32'(exp_c.rd), "commit rd");
        check_value(32'(commit_o.rd_we), 32'(exp_c.rd_we), "commit rd_we");
        check_value(commit_o.rd_data, exp_c.rd_data, "commit rd_data");
        check_value(32'(commit_o.trap), 32'(exp_c.trap), "commit trap");
        if (exp_c.trap) begin
          check_value(commit_o.redirect_pc, exp_c.redirect_pc, "commit redirect_pc");
          flush_due   = 1'b1;
          trap_target = exp_c.redirect_pc;
        end
      end
    end
  end

  initial begin
    core_pkg::ex_mem_t op;
    logic [31:0]       r;
    seed = 32'hd972_d42e;
    clk = 1'b0;
    rst = 1'b1;
    in_valid_i = 1'b0;
    in_data_i = '0;
    commit_ready_i = 1'b1;
    ready_mode = 0;
    stall_left = 0;
    errors = 0;
    dropped = 0;
    flush_due = 1'b0;
    trap_target = '0;
    pc_next = 32'h8000_0000;
    for (int i = 0; i < `DMEM_DEPTH; i++) m_mem[i] = '0;
    for (int i = 0; i < 32; i++) m_rf[i] = '0;
    for (int i = 0; i < 5; i++) m_csr[CSR_LIST[i]] = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // quiet after reset
    for (int i = 0; i < 6; i++) begin
      step_cycle();
      check_value(32'(commit_valid_o), 32'd0, "commit_valid_o idle after reset");
    end
    send_csr(`CSR_MSTATUS, 32'h0000_0008);  // first mstatus read sees zero
    send_csr(`CSR_MTVEC, 32'h0000_0100);
    send_csr(`CSR_MTVEC, 32'h0000_0200);
    drain("csr writes");

    for (int i = 0; i < 20; i++) begin
      op = make_op(K_ALU);
      if (i == 3) op.rd = '0;
      send_op(op);
    end
    drain("alu ops");

    for (int i = 0; i < 4; i++) send_mem(K_STORE, i * 7, $random(seed));
    for (int i = 0; i < 4; i++) send_mem(K_LOAD, i * 7, '0);
    send_mem(K_LOAD, 250, '0);  // never written
    send_mem(K_LOAD, 3, '0);
    ready_mode = 1;
    for (int i = 0; i < 4; i++) send_mem(K_LOAD, (i * 7) + 1, '0);
    drain("stores and loads");

    ready_mode = 2;  // load heavy mix against long commit stalls
    for (int i = 0; i < 80; i++) begin
      r = $random(seed);
      if (r[2:0] < 3'd4) send_op(make_op(K_LOAD));
      else if (r[2:0] == 3'd4) send_op(make_op(K_STORE));
      else if (r[2:0] == 3'd5) send_op(make_op(K_CSR));
      else send_op(make_op(K_ALU));
    end
    drain("back-pressure mix");

    // trap with younger non-store instructions behind it
    ready_mode = 1;
    send_csr(`CSR_MTVEC, 32'h0000_0400);
    send_op(make_op(K_TRAP));
    for (int i = 0; i < 4; i++) send_op(make_op(i[0] ? K_LOAD : K_ALU));
    drain("trap");
    ready_mode = 0;
    send_csr(`CSR_MEPC, 32'h0000_1000);
    send_csr(`CSR_MCAUSE, 32'h0000_0000);
    send_csr(`CSR_MSTATUS, 32'h0000_0000);
    drain("csr reads after trap");

    check_value(32'(dropped != 0), 32'd1, "younger instructions dropped by flush");
    for (int i = 0; i < 32; i++) begin
      check_value(mem_wb_top_i.u_wb_stage.rf[i], m_rf[i], $sformatf("register x%0d", i));
    end

    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+source
source/core_pkg.sv
source/data_mem.sv
source/mem_stage.sv
source/mem_wb_reg.sv
source/wb_stage.sv
source/mem_wb_top.sv
sim/tb_mem_wb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_mem_wb
RTL_TOP   ?= mem_wb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "$(PASS_STR)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
